//--- verilog/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath width in bits
`define PIPE_XLEN 16

// Architectural registers, register 0 reads as zero
`define PIPE_NREGS 16

// Words of data memory inside the core
`define PIPE_DMEM_DEPTH 16

// Tracker slots, one per stage that can hold an instruction
`define PIPE_MAX_INSTR 5

`endif

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    // Instruction word layout
    //   [15:12] opcode
    //   [11:8]  rd
    //   [7:4]   rs1
    //   [3:0]   rs2, or zero-extended immediate for ADDI, LD and ST
    localparam int INSTR_W = 16;
    localparam int OPC_W   = 4;
    localparam int REG_W   = 4;
    localparam int IMM_W   = 4;

    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 8;
    localparam int RS1_LSB = 4;
    localparam int RS2_LSB = 0;

    localparam int PC_W  = 8;
    // Latency and stall counters in the retire report
    localparam int CNT_W = 8;

    typedef enum logic [OPC_W-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        ADDI = 4'd3,
        LD   = 4'd4,
        ST   = 4'd5
    } opcode_t;

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, EMPTY} stage_t;

endpackage

//--- verilog/stage_if.sv
`timescale 1ns/100ps

interface stage_if;
    import pipe_pkg::*;

    // First cycle an instruction sits at the fetch pc
    logic               fetch_fire;
    logic [PC_W-1:0]    fetch_pc;
    logic [INSTR_W-1:0] fetch_instr;
    // Fetch and decode hold while high
    logic               stall;
    // Instruction in writeback completes this cycle
    logic               wb_fire;

    modport core (
        output fetch_fire, fetch_pc, fetch_instr, stall, wb_fire
    );

    modport tracker (
        input fetch_fire, fetch_pc, fetch_instr, stall, wb_fire
    );

endinterface

//--- verilog/hazard_unit.sv
`timescale 1ns/100ps
`include "pipe_config.svh"

module hazard_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [pipe_pkg::INSTR_W-1:0] dec_instr,
    input  logic [pipe_pkg::REG_W-1:0]   ex_rd,
    input  logic [pipe_pkg::REG_W-1:0]   mem_rd,
    input  logic                         ex_wr,
    input  logic                         mem_wr,
    output logic                         stall
);
    import pipe_pkg::*;

    opcode_t               op;
    logic [REG_W-1:0]      rd;
    logic [REG_W-1:0]      rs1;
    logic [REG_W-1:0]      rs2;
    // One bit per register: read by decode, pending in execute or memory
    logic [`PIPE_NREGS-1:0] read_mask;
    logic [`PIPE_NREGS-1:0] busy_mask;

    assign op  = opcode_t'(dec_instr[OPC_LSB +: OPC_W]);
    assign rd  = dec_instr[RD_LSB +: REG_W];
    assign rs1 = dec_instr[RS1_LSB +: REG_W];
    assign rs2 = dec_instr[RS2_LSB +: REG_W];

    always_comb begin
        read_mask = '0;
        busy_mask = '0;
        case (op)
            ADD, SUB: begin
                read_mask[rs1] = 1'b1;
                read_mask[rs2] = 1'b1;
            end
            ADDI, LD: read_mask[rs1] = 1'b1;
            // Store data comes from rd
            ST: begin
                read_mask[rd]  = 1'b1;
                read_mask[rs1] = 1'b1;
            end
            default: read_mask = '0;
        endcase
        if (ex_wr) begin
            busy_mask[ex_rd] = 1'b1;
        end
        if (mem_wr) begin
            busy_mask[mem_rd] = 1'b1;
        end
        busy_mask[0] = 1'b0;
    end

    assign stall = |(read_mask & busy_mask);

    // Worst case is a producer one ahead, gone from memory after two cycles
    a_stall_max_two: assert property (@(posedge clk) disable iff (rst)
        stall && $past(stall) |=> !stall)
        else $error("stall held longer than two cycles");

endmodule

//--- verilog/pipe_core.sv
`timescale 1ns/100ps
`include "pipe_config.svh"

module pipe_core (
    input  logic                         clk,
    input  logic                         rst,
    output logic [pipe_pkg::PC_W-1:0]    pc,
    input  logic [pipe_pkg::INSTR_W-1:0] instr,
    output logic                         wb_valid,
    output logic [pipe_pkg::REG_W-1:0]   wb_rd,
    output logic [`PIPE_XLEN-1:0]        wb_data,
    stage_if.core                        ev
);
    import pipe_pkg::*;

    localparam int DADDR_W = $clog2(`PIPE_DMEM_DEPTH);

    logic run;
    logic fetch_held;
    logic stall;

    logic [`PIPE_XLEN-1:0] regs [`PIPE_NREGS];
    logic [`PIPE_XLEN-1:0] dmem [`PIPE_DMEM_DEPTH];

    // IF/ID
    logic               ifid_valid;
    logic [INSTR_W-1:0] ifid_instr;

    // Decode
    opcode_t               dec_op;
    logic [REG_W-1:0]      dec_rd;
    logic [REG_W-1:0]      dec_rs1;
    logic [REG_W-1:0]      dec_rs2;
    logic                  dec_wr;
    logic [`PIPE_XLEN-1:0] rs1_val;
    logic [`PIPE_XLEN-1:0] rs2_val;
    logic [`PIPE_XLEN-1:0] rd_val;
    logic [`PIPE_XLEN-1:0] imm_ext;
    logic [`PIPE_XLEN-1:0] dec_b;
    logic [INSTR_W-1:0]    hz_instr;

    // ID/EX
    logic                  idex_valid;
    logic                  idex_wr;
    opcode_t               idex_op;
    logic [REG_W-1:0]      idex_rd;
    logic [`PIPE_XLEN-1:0] idex_a;
    logic [`PIPE_XLEN-1:0] idex_b;
    logic [`PIPE_XLEN-1:0] idex_st;
    logic [`PIPE_XLEN-1:0] ex_res;

    // EX/MEM
    logic                  exmem_valid;
    logic                  exmem_wr;
    opcode_t               exmem_op;
    logic [REG_W-1:0]      exmem_rd;
    logic [`PIPE_XLEN-1:0] exmem_res;
    logic [`PIPE_XLEN-1:0] exmem_st;
    logic [DADDR_W-1:0]    mem_addr;
    logic [`PIPE_XLEN-1:0] mem_res;

    // MEM/WB
    logic                  memwb_valid;
    logic                  memwb_wr;
    logic [REG_W-1:0]      memwb_rd;
    logic [`PIPE_XLEN-1:0] memwb_data;

    // Register read with writeback passed through in the same cycle
    function automatic logic [`PIPE_XLEN-1:0] read_reg(input logic [REG_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_valid && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    assign dec_op  = opcode_t'(ifid_instr[OPC_LSB +: OPC_W]);
    assign dec_rd  = ifid_instr[RD_LSB +: REG_W];
    assign dec_rs1 = ifid_instr[RS1_LSB +: REG_W];
    assign dec_rs2 = ifid_instr[RS2_LSB +: REG_W];
    assign imm_ext = {{(`PIPE_XLEN-IMM_W){1'b0}}, ifid_instr[RS2_LSB +: IMM_W]};
    assign dec_b   = (dec_op == ADD || dec_op == SUB) ? rs2_val : imm_ext;
    assign dec_wr  = (dec_op inside {ADD, SUB, ADDI, LD}) && dec_rd != '0;
    // An empty decode slot looks like a NOP
    assign hz_instr = ifid_valid ? ifid_instr : '0;

    always_comb begin
        rs1_val = read_reg(dec_rs1);
        rs2_val = read_reg(dec_rs2);
        rd_val  = read_reg(dec_rd);
    end

    hazard_unit hz0 (
        .clk      (clk),
        .rst      (rst),
        .dec_instr(hz_instr),
        .ex_rd    (idex_rd),
        .mem_rd   (exmem_rd),
        .ex_wr    (idex_valid && idex_wr),
        .mem_wr   (exmem_valid && exmem_wr),
        .stall    (stall)
    );

    assign ex_res   = (idex_op == SUB) ? idex_a - idex_b : idex_a + idex_b;
    assign mem_addr = exmem_res[DADDR_W-1:0];
    assign mem_res  = (exmem_op == LD) ? dmem[mem_addr] : exmem_res;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run         <= 1'b0;
            fetch_held  <= 1'b0;
            pc          <= '0;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
        end else begin
            run        <= 1'b1;
            fetch_held <= stall;
            if (run && !stall) begin
                pc <= pc + 1'b1;
            end
            if (!stall) begin
                ifid_valid <= run;
            end
            // Bubble into execute while decode is held
            idex_valid  <= ifid_valid && !stall;
            exmem_valid <= idex_valid;
            memwb_valid <= exmem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_instr <= instr;
        end
        idex_op    <= dec_op;
        idex_rd    <= dec_rd;
        idex_wr    <= dec_wr;
        idex_a     <= rs1_val;
        idex_b     <= dec_b;
        idex_st    <= rd_val;
        exmem_op   <= idex_op;
        exmem_rd   <= idex_rd;
        exmem_wr   <= idex_wr;
        exmem_res  <= ex_res;
        exmem_st   <= idex_st;
        memwb_rd   <= exmem_rd;
        memwb_wr   <= exmem_wr;
        memwb_data <= mem_res;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (exmem_valid && exmem_op == ST) begin
            dmem[mem_addr] <= exmem_st;
        end
    end

    assign wb_valid = memwb_valid && memwb_wr;
    assign wb_rd    = memwb_rd;
    assign wb_data  = memwb_data;

    assign ev.fetch_fire  = run && !fetch_held;
    assign ev.fetch_pc    = pc;
    assign ev.fetch_instr = instr;
    assign ev.stall       = stall;
    assign ev.wb_fire     = memwb_valid;

    // Decode drops rd 0 three stages earlier
    a_wb_no_r0: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_rd != '0)
        else $error("writeback to register 0");

endmodule

//--- verilog/pipeline_tracker.sv
`timescale 1ns/100ps
`include "pipe_config.svh"

module pipeline_tracker (
    input  logic                         clk,
    input  logic                         rst,
    stage_if.tracker                     ev,
    output logic                         retire_valid,
    output logic [pipe_pkg::PC_W-1:0]    retire_pc,
    output logic [pipe_pkg::INSTR_W-1:0] retire_instr,
    output logic [pipe_pkg::CNT_W-1:0]   retire_latency,
    output logic [pipe_pkg::CNT_W-1:0]   retire_stalls
);
    import pipe_pkg::*;

    localparam int SLOT_W = $clog2(`PIPE_MAX_INSTR);

    stage_t             slot_stage  [`PIPE_MAX_INSTR];
    logic [PC_W-1:0]    slot_pc     [`PIPE_MAX_INSTR];
    logic [INSTR_W-1:0] slot_instr  [`PIPE_MAX_INSTR];
    logic [CNT_W-1:0]   slot_stamp  [`PIPE_MAX_INSTR];
    logic [CNT_W-1:0]   slot_stalls [`PIPE_MAX_INSTR];

    logic [CNT_W-1:0]  cycle_cnt;
    logic              free_found;
    logic [SLOT_W-1:0] free_idx;
    logic              wb_found;
    logic [SLOT_W-1:0] wb_idx;

    function automatic stage_t next_stage(input stage_t cur, input logic hold,
                                          input logic retire);
        case (cur)
            FETCH:     return hold ? FETCH : DECODE;
            DECODE:    return hold ? DECODE : EXECUTE;
            EXECUTE:   return MEMORY;
            MEMORY:    return WRITEBACK;
            WRITEBACK: return retire ? EMPTY : WRITEBACK;
            default:   return EMPTY;
        endcase
    endfunction

    // Lowest free slot, and the one slot in writeback
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        wb_found   = 1'b0;
        wb_idx     = '0;
        for (int i = `PIPE_MAX_INSTR - 1; i >= 0; i--) begin
            if (slot_stage[i] == EMPTY) begin
                free_found = 1'b1;
                free_idx   = SLOT_W'(i);
            end
            if (slot_stage[i] == WRITEBACK) begin
                wb_found = 1'b1;
                wb_idx   = SLOT_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt    <= '0;
            retire_valid <= 1'b0;
            for (int i = 0; i < `PIPE_MAX_INSTR; i++) begin
                slot_stage[i] <= EMPTY;
            end
        end else begin
            cycle_cnt    <= cycle_cnt + 1'b1;
            retire_valid <= ev.wb_fire;
            for (int i = 0; i < `PIPE_MAX_INSTR; i++) begin
                slot_stage[i] <= next_stage(slot_stage[i], ev.stall, ev.wb_fire);
            end
            // New entry starts in FETCH and follows the FETCH rule this same cycle
            if (ev.fetch_fire && free_found) begin
                slot_stage[free_idx] <= next_stage(FETCH, ev.stall, 1'b0);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `PIPE_MAX_INSTR; i++) begin
            if ((slot_stage[i] == FETCH || slot_stage[i] == DECODE) && ev.stall) begin
                slot_stalls[i] <= slot_stalls[i] + 1'b1;
            end
        end
        if (ev.fetch_fire && free_found) begin
            slot_pc[free_idx]     <= ev.fetch_pc;
            slot_instr[free_idx]  <= ev.fetch_instr;
            slot_stamp[free_idx]  <= cycle_cnt;
            slot_stalls[free_idx] <= CNT_W'(ev.stall);
        end
        if (ev.wb_fire) begin
            retire_pc      <= slot_pc[wb_idx];
            retire_instr   <= slot_instr[wb_idx];
            retire_latency <= cycle_cnt - slot_stamp[wb_idx];
            retire_stalls  <= slot_stalls[wb_idx];
        end
    end

    a_wb_has_slot: assert property (@(posedge clk) disable iff (rst)
        ev.wb_fire |-> wb_found)
        else $error("wb_fire with no slot in writeback");

    a_fetch_has_room: assert property (@(posedge clk) disable iff (rst)
        ev.fetch_fire |-> free_found)
        else $error("fetch_fire with tracker table full");

endmodule

//--- verilog/pipe_top.sv
`timescale 1ns/100ps
`include "pipe_config.svh"

module pipe_top (
    input  logic                         clk,
    input  logic                         rst,
    output logic [pipe_pkg::PC_W-1:0]    pc,
    input  logic [pipe_pkg::INSTR_W-1:0] instr,
    output logic                         wb_valid,
    output logic [pipe_pkg::REG_W-1:0]   wb_rd,
    output logic [`PIPE_XLEN-1:0]        wb_data,
    output logic                         retire_valid,
    output logic [pipe_pkg::PC_W-1:0]    retire_pc,
    output logic [pipe_pkg::INSTR_W-1:0] retire_instr,
    output logic [pipe_pkg::CNT_W-1:0]   retire_latency,
    output logic [pipe_pkg::CNT_W-1:0]   retire_stalls
);

    stage_if ev0 ();

    pipe_core core0 (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .instr   (instr),
        .wb_valid(wb_valid),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .ev      (ev0)
    );

    pipeline_tracker trk0 (
        .clk           (clk),
        .rst           (rst),
        .ev            (ev0),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_instr  (retire_instr),
        .retire_latency(retire_latency),
        .retire_stalls (retire_stalls)
    );

endmodule

//--- testbench/tb_pipe_top.sv
`timescale 1ns/100ps
`include "pipe_config.svh"

module tb_pipe_top;
    import pipe_pkg::*;

    localparam int N_FIXED  = 17;
    localparam int N_RANDOM = 40;
    localparam int PROG_LEN = N_FIXED + N_RANDOM;
    localparam int MAX_WAIT = 1000;

    logic                  clk;
    logic                  rst;
    logic [PC_W-1:0]       pc;
    logic [INSTR_W-1:0]    instr;
    logic                  wb_valid;
    logic [REG_W-1:0]      wb_rd;
    logic [`PIPE_XLEN-1:0] wb_data;
    logic                  retire_valid;
    logic [PC_W-1:0]       retire_pc;
    logic [INSTR_W-1:0]    retire_instr;
    logic [CNT_W-1:0]      retire_latency;
    logic [CNT_W-1:0]      retire_stalls;
    logic                  ret_writes;

    logic [INSTR_W-1:0]    rom [256];
    int                    exp_stalls [PROG_LEN];
    logic [REG_W-1:0]      exp_rd [$];
    logic [`PIPE_XLEN-1:0] exp_data [$];
    int                    seed;
    int                    error_count;
    int                    next_retire;
    int                    cycles;

    pipe_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_instr  (retire_instr),
        .retire_latency(retire_latency),
        .retire_stalls (retire_stalls)
    );

    function automatic logic [INSTR_W-1:0] enc(input opcode_t op, input int rd,
                                               input int rs1, input int lo);
        return {op, rd[3:0], rs1[3:0], lo[3:0]};
    endfunction

    function automatic logic writes_reg(input logic [INSTR_W-1:0] w);
        opcode_t op;
        op = opcode_t'(w[15:12]);
        return (op inside {ADD, SUB, ADDI, LD}) && w[11:8] != 4'd0;
    endfunction

    function automatic logic reads_reg(input logic [INSTR_W-1:0] w, input logic [REG_W-1:0] r);
        case (opcode_t'(w[15:12]))
            ADD, SUB: return w[7:4] == r || w[3:0] == r;
            ADDI, LD: return w[7:4] == r;
            // Store data comes from rd
            ST:       return w[11:8] == r || w[7:4] == r;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic logic conflict(input logic [INSTR_W-1:0] older,
                                      input logic [INSTR_W-1:0] younger);
        return writes_reg(older) && reads_reg(younger, older[11:8]);
    endfunction

    task automatic build_program();
        logic [31:0] r;
        int          op_num;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
        end
        rom[0]  = enc(ADDI, 1, 0, 5);
        rom[1]  = enc(ADDI, 2, 1, 3);
        rom[2]  = enc(ADD,  3, 1, 2);
        rom[3]  = enc(NOP,  0, 0, 0);
        rom[4]  = enc(SUB,  4, 3, 1);
        rom[5]  = enc(ST,   4, 0, 2);
        rom[6]  = enc(NOP,  0, 0, 0);
        rom[7]  = enc(NOP,  0, 0, 0);
        rom[8]  = enc(LD,   5, 0, 2);
        rom[9]  = enc(NOP,  0, 0, 0);
        rom[10] = enc(NOP,  0, 0, 0);
        rom[11] = enc(ADDI, 6, 5, 1);
        rom[12] = enc(ST,   6, 1, 1);
        rom[13] = enc(LD,   7, 0, 6);
        rom[14] = enc(SUB,  8, 7, 6);
        // Write to r0 must vanish
        rom[15] = enc(ADD,  0, 1, 1);
        rom[16] = enc(ADD,  9, 0, 1);
        for (int i = N_FIXED; i < PROG_LEN; i++) begin
            r      = $random(seed);
            op_num = int'(r[15:0]) % 6;
            rom[i] = {op_num[3:0], r[19:16], r[23:20], r[27:24]};
        end
    endtask

    task automatic run_reference();
        logic [`PIPE_XLEN-1:0] regs [`PIPE_NREGS];
        logic [`PIPE_XLEN-1:0] dmem [`PIPE_DMEM_DEPTH];
        int                    exec_cyc [PROG_LEN + 2];
        logic [INSTR_W-1:0]    w;
        logic [`PIPE_XLEN-1:0] a;
        logic [`PIPE_XLEN-1:0] sum;
        logic [`PIPE_XLEN-1:0] v;
        int                    x;
        for (int i = 0; i < `PIPE_NREGS; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < `PIPE_DMEM_DEPTH; i++) begin
            dmem[i] = '0;
        end
        // Two virtual entries stand for the fetch and decode cycles of instruction 0
        exec_cyc[0] = 1;
        exec_cyc[1] = 2;
        for (int i = 0; i < PROG_LEN; i++) begin
            w   = rom[i];
            a   = regs[w[7:4]];
            sum = a + {{(`PIPE_XLEN-4){1'b0}}, w[3:0]};
            case (opcode_t'(w[15:12]))
                ADD:     v = a + regs[w[3:0]];
                SUB:     v = a - regs[w[3:0]];
                LD:      v = dmem[sum[3:0]];
                default: v = sum;
            endcase
            if (opcode_t'(w[15:12]) == ST) begin
                dmem[sum[3:0]] = regs[w[11:8]];
            end
            if (writes_reg(w)) begin
                regs[w[11:8]] = v;
                exp_rd.push_back(w[11:8]);
                exp_data.push_back(v);
            end
            // Execute follows the previous one, and trails a producer by three
            x = exec_cyc[i + 1] + 1;
            if (i >= 1 && conflict(rom[i - 1], w) && exec_cyc[i + 1] + 3 > x) begin
                x = exec_cyc[i + 1] + 3;
            end
            if (i >= 2 && conflict(rom[i - 2], w) && exec_cyc[i] + 3 > x) begin
                x = exec_cyc[i] + 3;
            end
            exec_cyc[i + 2] = x;
            exp_stalls[i]   = x - exec_cyc[i] - 2;
        end
    endtask

    assign ret_writes = writes_reg(retire_instr);

    a_reset_idle: assert property (@(posedge clk)
        $past(rst) |-> pc == '0 && !wb_valid && !retire_valid)
        else begin
            error_count++;
            $display("[ERROR] %0t pc/wb_valid/retire_valid expected 0/0/0 got %0d/%0b/%0b",
                     $time, $sampled(pc), $sampled(wb_valid), $sampled(retire_valid));
        end

    a_retire_rd: assert property (@(posedge clk) disable iff (rst)
        retire_valid && ret_writes |-> $past(wb_valid) && $past(wb_rd) == retire_instr[11:8])
        else begin
            error_count++;
            $display("[ERROR] %0t retire of pc %0d has no writeback of r%0d one cycle before",
                     $time, $sampled(retire_pc), $sampled(retire_instr[11:8]));
        end

    a_wb_retires: assert property (@(posedge clk) disable iff (rst)
        wb_valid |=> retire_valid)
        else begin
            error_count++;
            $display("[ERROR] %0t writeback was not followed by a retire", $time);
        end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Combinational ROM, refreshed while pc is stable
    always @(negedge clk) begin
        instr = rom[pc];
    end

    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_rd.size() == 0) begin
                error_count++;
                $display("[ERROR] %0t writeback to r%0d with no writing instruction left",
                         $time, wb_rd);
            end else begin
                assert (wb_rd == exp_rd[0]) else begin
                    error_count++;
                    $display("[ERROR] %0t wb_rd expected %0d got %0d", $time, exp_rd[0], wb_rd);
                end
                assert (wb_data == exp_data[0]) else begin
                    error_count++;
                    $display("[ERROR] %0t wb_data expected %0h got %0h", $time,
                             exp_data[0], wb_data);
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
        if (!rst && retire_valid && next_retire < PROG_LEN) begin
            assert (retire_pc == PC_W'(next_retire)) else begin
                error_count++;
                $display("[ERROR] %0t retire_pc expected %0d got %0d", $time,
                         next_retire, retire_pc);
            end
            assert (retire_instr == rom[next_retire]) else begin
                error_count++;
                $display("[ERROR] %0t retire_instr expected %h got %h", $time,
                         rom[next_retire], retire_instr);
            end
            assert (retire_stalls == CNT_W'(exp_stalls[next_retire])) else begin
                error_count++;
                $display("[ERROR] %0t retire_stalls expected %0d got %0d", $time,
                         exp_stalls[next_retire], retire_stalls);
            end
            assert (retire_latency == CNT_W'(exp_stalls[next_retire] + 4)) else begin
                error_count++;
                $display("[ERROR] %0t retire_latency expected %0d got %0d", $time,
                         exp_stalls[next_retire] + 4, retire_latency);
            end
            next_retire++;
        end
    end

    initial begin
        rst         = 1'b1;
        instr       = '0;
        seed        = 14;
        error_count = 0;
        next_retire = 0;
        cycles      = 0;
        build_program();
        run_reference();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        while (next_retire < PROG_LEN && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (next_retire < PROG_LEN) begin
            error_count++;
            $display("Timed out with %0d of %0d instructions retired", next_retire, PROG_LEN);
        end
        if (exp_rd.size() != 0) begin
            error_count++;
            $display("%0d expected writebacks never arrived", exp_rd.size());
        end
        $display("Run finished after %0d cycles with %0d errors", cycles, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/pipe_pkg.sv
verilog/stage_if.sv
verilog/hazard_unit.sv
verilog/pipe_core.sv
verilog/pipeline_tracker.sv
verilog/pipe_top.sv
testbench/tb_pipe_top.sv

//--- Makefile
TOP = tb_pipe_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module pipe_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
